// File: Bender.yml
package:
  name: dual_pipe

sources:
  - files:
      - hdl/dual_pipe_pkg.sv
      - hdl/reg_file.sv
      - hdl/issue_stage.sv
      - hdl/exec_stage.sv
      - hdl/wb_stage.sv
      - hdl/dual_pipe_top.sv
  - target: test
    files:
      - testbench/tb_dual_pipe.sv

// File: dual_pipe.f
hdl/dual_pipe_pkg.sv
hdl/reg_file.sv
hdl/issue_stage.sv
hdl/exec_stage.sv
hdl/wb_stage.sv
hdl/dual_pipe_top.sv
testbench/tb_dual_pipe.sv

// File: hdl/dual_pipe_pkg.sv
package dual_pipe_pkg;

    // **********************************************************************
    // sizes
    // **********************************************************************
    localparam int XLEN         = 32;
    localparam int REG_ADDR_W   = 5;
    localparam int NUM_REGS     = 32;
    localparam int IMM_W        = 16;
    localparam int NUM_LANES    = 2;
    localparam int NUM_RD_PORTS = 4;

    // **********************************************************************
    // opcodes
    // **********************************************************************
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_SLT = 3'd7
    } alu_op_e;

    // **********************************************************************
    // stage buses
    // **********************************************************************

    // one instruction as it arrives from fetch
    typedef struct packed {
        alu_op_e                op;
        logic                   use_imm;
        logic [IMM_W-1:0]       imm;
        logic [REG_ADDR_W-1:0]  src1;
        logic [REG_ADDR_W-1:0]  src2;
        logic [REG_ADDR_W-1:0]  dest;
        logic                   gr_we;
        logic [XLEN-1:0]        pc;
    } inst_t;

    // slot1 is older in program order
    typedef struct packed {
        inst_t slot1;
        inst_t slot2;
    } bundle_t;

    // one issue to execute lane
    typedef struct packed {
        alu_op_e                op;
        logic [XLEN-1:0]        opnd1;
        logic [XLEN-1:0]        opnd2;
        logic                   chain1;
        logic                   chain2;
        logic                   gr_we;
        logic [REG_ADDR_W-1:0]  dest;
        logic [XLEN-1:0]        pc;
    } ds_to_es_t;

    // one execute to writeback lane of 70 bits
    typedef struct packed {
        logic                   gr_we;
        logic [REG_ADDR_W-1:0]  dest;
        logic [XLEN-1:0]        final_result;
        logic [XLEN-1:0]        pc;
    } es_to_ws_t;

    // one register file write port
    typedef struct packed {
        logic                   we;
        logic [REG_ADDR_W-1:0]  waddr;
        logic [XLEN-1:0]        wdata;
    } rf_wr_t;

endpackage

// File: hdl/dual_pipe_top.sv
`timescale 1ns/10ps

module dual_pipe_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     issue_valid,
    input  dual_pipe_pkg::bundle_t   issue_bundle,
    output logic                     issue_ready,
    output logic                     retire_valid,
    output dual_pipe_pkg::es_to_ws_t retire_lane1,
    output dual_pipe_pkg::es_to_ws_t retire_lane2,
    input  logic                     retire_ready
);

    import dual_pipe_pkg::*;

    // issue to execute
    logic                                    ds_to_es_valid;
    ds_to_es_t [NUM_LANES-1:0]               ds_to_es_bus;
    logic                                    es_allowin;

    // execute to writeback
    logic                                    es_to_ws_valid;
    es_to_ws_t [NUM_LANES-1:0]               es_to_ws_bus;
    logic                                    ws_allowin;

    // writeback hold, forwarding and register file
    logic                                    ws_valid;
    es_to_ws_t [NUM_LANES-1:0]               ws_lanes;
    rf_wr_t    [NUM_LANES-1:0]               rf_wr;
    logic      [NUM_RD_PORTS-1:0][REG_ADDR_W-1:0] rf_raddr;
    logic      [NUM_RD_PORTS-1:0][XLEN-1:0]       rf_rdata;

    issue_stage u_issue (
        .clk            (clk),
        .reset          (reset),
        .issue_valid    (issue_valid),
        .issue_bundle   (issue_bundle),
        .issue_ready    (issue_ready),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_fwd_valid   (es_to_ws_valid),
        .es_fwd         (es_to_ws_bus),
        .ws_fwd_valid   (ws_valid),
        .ws_fwd         (ws_lanes),
        .rf_raddr       (rf_raddr),
        .rf_rdata       (rf_rdata)
    );

    exec_stage u_exec (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_allowin     (es_allowin),
        .ws_allowin     (ws_allowin),
        .es_to_ws_valid (es_to_ws_valid),
        .es_to_ws_bus   (es_to_ws_bus)
    );

    wb_stage u_wb (
        .clk            (clk),
        .reset          (reset),
        .es_to_ws_valid (es_to_ws_valid),
        .es_to_ws_bus   (es_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .ws_valid       (ws_valid),
        .ws_lanes       (ws_lanes),
        .rf_wr          (rf_wr),
        .retire_valid   (retire_valid),
        .retire_lane1   (retire_lane1),
        .retire_lane2   (retire_lane2),
        .retire_ready   (retire_ready)
    );

    reg_file u_rf (
        .clk            (clk),
        .reset          (reset),
        .rf_wr          (rf_wr),
        .raddr          (rf_raddr),
        .rdata          (rf_rdata)
    );

endmodule

// File: hdl/exec_stage.sv
`timescale 1ns/10ps

module exec_stage (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 ds_to_es_valid,
    input  dual_pipe_pkg::ds_to_es_t [dual_pipe_pkg::NUM_LANES-1:0] ds_to_es_bus,
    output logic                                                 es_allowin,
    input  logic                                                 ws_allowin,
    output logic                                                 es_to_ws_valid,
    output dual_pipe_pkg::es_to_ws_t [dual_pipe_pkg::NUM_LANES-1:0] es_to_ws_bus
);

    import dual_pipe_pkg::*;

    logic                             es_valid;
    logic                             es_ready_go;
    ds_to_es_t [NUM_LANES-1:0]        lanes_r;
    logic      [NUM_LANES-1:0][XLEN-1:0] opnd1;
    logic      [NUM_LANES-1:0][XLEN-1:0] opnd2;
    logic      [NUM_LANES-1:0][XLEN-1:0] result;

    function automatic logic [XLEN-1:0] alu(
        input alu_op_e         op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic [XLEN-1:0] r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << b[4:0];
            OP_SRL:  r = a >> b[4:0];
            OP_SLT:  r = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            default: r = '0;
        endcase
        return r;
    endfunction

    // **********************************************************************
    // handshake
    // **********************************************************************
    assign es_ready_go    = 1'b1;
    assign es_allowin     = !es_valid || (es_ready_go && ws_allowin);
    assign es_to_ws_valid = es_valid && es_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            lanes_r <= ds_to_es_bus;
        end
    end

    // **********************************************************************
    // alu lanes
    // **********************************************************************
    assign opnd1[0]  = lanes_r[0].opnd1;
    assign opnd2[0]  = lanes_r[0].opnd2;
    assign result[0] = alu(lanes_r[0].op, opnd1[0], opnd2[0]);

    // lane 2 may take lane 1 result directly
    assign opnd1[1]  = lanes_r[1].chain1 ? result[0] : lanes_r[1].opnd1;
    assign opnd2[1]  = lanes_r[1].chain2 ? result[0] : lanes_r[1].opnd2;
    assign result[1] = alu(lanes_r[1].op, opnd1[1], opnd2[1]);

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            es_to_ws_bus[l].gr_we        = lanes_r[l].gr_we;
            es_to_ws_bus[l].dest         = lanes_r[l].dest;
            es_to_ws_bus[l].final_result = result[l];
            es_to_ws_bus[l].pc           = lanes_r[l].pc;
        end
    end

    // issue only chains the younger lane
    a_no_chain_lane1: assert property (@(posedge clk) disable iff (reset)
        es_valid |-> !lanes_r[0].chain1 && !lanes_r[0].chain2);

endmodule

// File: hdl/issue_stage.sv
`timescale 1ns/10ps

module issue_stage (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 issue_valid,
    input  dual_pipe_pkg::bundle_t                               issue_bundle,
    output logic                                                 issue_ready,
    input  logic                                                 es_allowin,
    output logic                                                 ds_to_es_valid,
    output dual_pipe_pkg::ds_to_es_t [dual_pipe_pkg::NUM_LANES-1:0] ds_to_es_bus,
    input  logic                                                 es_fwd_valid,
    input  dual_pipe_pkg::es_to_ws_t [dual_pipe_pkg::NUM_LANES-1:0] es_fwd,
    input  logic                                                 ws_fwd_valid,
    input  dual_pipe_pkg::es_to_ws_t [dual_pipe_pkg::NUM_LANES-1:0] ws_fwd,
    output logic [dual_pipe_pkg::NUM_RD_PORTS-1:0][dual_pipe_pkg::REG_ADDR_W-1:0] rf_raddr,
    input  logic [dual_pipe_pkg::NUM_RD_PORTS-1:0][dual_pipe_pkg::XLEN-1:0]       rf_rdata
);

    import dual_pipe_pkg::*;

    logic                                ds_valid;
    logic                                ds_ready_go;
    logic                                ds_allowin;
    bundle_t                             bundle_r;
    inst_t [NUM_LANES-1:0]               slot;
    logic  [NUM_RD_PORTS-1:0][XLEN-1:0]  src_val;
    logic                                lane1_writes;

    // **********************************************************************
    // handshake
    // **********************************************************************
    assign ds_ready_go    = 1'b1;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign issue_ready    = ds_allowin;
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && ds_allowin) begin
            bundle_r <= issue_bundle;
        end
    end

    assign slot[0] = bundle_r.slot1;
    assign slot[1] = bundle_r.slot2;

    // read ports 0/1 for lane 1, 2/3 for lane 2
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            rf_raddr[2*l]   = slot[l].src1;
            rf_raddr[2*l+1] = slot[l].src2;
        end
    end

    // **********************************************************************
    // operand forwarding
    // **********************************************************************
    // later checks override earlier ones, so the youngest producer wins
    always_comb begin
        for (int i = 0; i < NUM_RD_PORTS; i++) begin
            src_val[i] = rf_rdata[i];
            for (int l = 0; l < NUM_LANES; l++) begin
                if (ws_fwd_valid && ws_fwd[l].gr_we && ws_fwd[l].dest == rf_raddr[i]) begin
                    src_val[i] = ws_fwd[l].final_result;
                end
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                if (es_fwd_valid && es_fwd[l].gr_we && es_fwd[l].dest == rf_raddr[i]) begin
                    src_val[i] = es_fwd[l].final_result;
                end
            end
            if (rf_raddr[i] == '0) begin
                src_val[i] = '0;
            end
        end
    end

    // r0 dest never chains
    assign lane1_writes = slot[0].gr_we && (slot[0].dest != '0);

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            ds_to_es_bus[l].op     = slot[l].op;
            ds_to_es_bus[l].opnd1  = src_val[2*l];
            ds_to_es_bus[l].opnd2  = slot[l].use_imm ?
                {{(XLEN-IMM_W){slot[l].imm[IMM_W-1]}}, slot[l].imm} : src_val[2*l+1];
            ds_to_es_bus[l].chain1 = 1'b0;
            ds_to_es_bus[l].chain2 = 1'b0;
            ds_to_es_bus[l].gr_we  = slot[l].gr_we;
            ds_to_es_bus[l].dest   = slot[l].dest;
            ds_to_es_bus[l].pc     = slot[l].pc;
        end
        // same-bundle dependency resolved in execute
        if (lane1_writes) begin
            ds_to_es_bus[1].chain1 = (slot[1].src1 == slot[0].dest);
            ds_to_es_bus[1].chain2 = !slot[1].use_imm && (slot[1].src2 == slot[0].dest);
        end
    end

    // fetch must hold a stalled bundle
    a_issue_stable: assert property (@(posedge clk) disable iff (reset)
        issue_valid && !issue_ready |=> $stable(issue_bundle));

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                                              clk,
    input  logic                                              reset,
    input  dual_pipe_pkg::rf_wr_t [dual_pipe_pkg::NUM_LANES-1:0] rf_wr,
    input  logic [dual_pipe_pkg::NUM_RD_PORTS-1:0][dual_pipe_pkg::REG_ADDR_W-1:0] raddr,
    output logic [dual_pipe_pkg::NUM_RD_PORTS-1:0][dual_pipe_pkg::XLEN-1:0]       rdata
);

    import dual_pipe_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // **********************************************************************
    // write ports
    // **********************************************************************
    // port 2 is applied last, so it wins a same-address collision
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_LANES; p++) begin
                if (rf_wr[p].we && rf_wr[p].waddr != '0) begin
                    regs[rf_wr[p].waddr] <= rf_wr[p].wdata;
                end
            end
        end
    end

    // **********************************************************************
    // read ports
    // **********************************************************************
    always_comb begin
        for (int i = 0; i < NUM_RD_PORTS; i++) begin
            if (raddr[i] == '0) begin
                rdata[i] = '0;
            end else begin
                rdata[i] = regs[raddr[i]];
            end
        end
    end

endmodule

// File: hdl/wb_stage.sv
`timescale 1ns/10ps

module wb_stage (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 es_to_ws_valid,
    input  dual_pipe_pkg::es_to_ws_t [dual_pipe_pkg::NUM_LANES-1:0] es_to_ws_bus,
    output logic                                                 ws_allowin,
    output logic                                                 ws_valid,
    output dual_pipe_pkg::es_to_ws_t [dual_pipe_pkg::NUM_LANES-1:0] ws_lanes,
    output dual_pipe_pkg::rf_wr_t    [dual_pipe_pkg::NUM_LANES-1:0] rf_wr,
    output logic                                                 retire_valid,
    output dual_pipe_pkg::es_to_ws_t                             retire_lane1,
    output dual_pipe_pkg::es_to_ws_t                             retire_lane2,
    input  logic                                                 retire_ready
);

    import dual_pipe_pkg::*;

    logic                      ws_ready_go;
    es_to_ws_t [NUM_LANES-1:0] lanes_r;

    // back-pressure from the retire port
    assign ws_ready_go = retire_ready;
    assign ws_allowin  = !ws_valid || ws_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= es_to_ws_valid;
        end
    end

    // both lanes share the one valid bit
    always_ff @(posedge clk) begin
        if (es_to_ws_valid && ws_allowin) begin
            lanes_r <= es_to_ws_bus;
        end
    end

    assign ws_lanes = lanes_r;

    // commit on the retire handshake
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            rf_wr[l].we    = lanes_r[l].gr_we && ws_valid && retire_ready;
            rf_wr[l].waddr = lanes_r[l].dest;
            rf_wr[l].wdata = lanes_r[l].final_result;
        end
    end

    assign retire_valid = ws_valid;
    assign retire_lane1 = lanes_r[0];
    assign retire_lane2 = lanes_r[1];

    a_retire_hold: assert property (@(posedge clk) disable iff (reset)
        retire_valid && !retire_ready |=>
            retire_valid && $stable(retire_lane1) && $stable(retire_lane2));

endmodule

// File: testbench/tb_dual_pipe.sv
`timescale 1ns/10ps

module tb_dual_pipe;

    import dual_pipe_pkg::*;

    localparam int          NUM_BUNDLES  = 400;
    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 8;
    localparam int          TIMEOUT_NS   = NUM_BUNDLES * 8 * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED    = 32'h6f12_0222;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    // expected results of one bundle in retire order
    typedef struct packed {
        es_to_ws_t lane1;
        es_to_ws_t lane2;
    } retire_pair_t;

    logic            clk;
    logic            reset;
    logic            issue_valid;
    bundle_t         issue_bundle;
    logic            issue_ready;
    logic            retire_valid;
    es_to_ws_t       retire_lane1;
    es_to_ws_t       retire_lane2;
    logic            retire_ready;

    logic [31:0]     lfsr;
    logic [XLEN-1:0] model_regs [NUM_REGS];
    retire_pair_t    exp_q [$];
    int              accepted;
    int              retired;
    logic            issue_fire;
    logic            s_retire_valid;
    logic            s_issue_ready;
    logic            pending;
    logic [XLEN-1:0] next_pc;

    dual_pipe_top uut (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_bundle (issue_bundle),
        .issue_ready  (issue_ready),
        .retire_valid (retire_valid),
        .retire_lane1 (retire_lane1),
        .retire_lane2 (retire_lane2),
        .retire_ready (retire_ready)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // **********************************************************************
    // random source
    // **********************************************************************
    function automatic logic lfsr_next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ LFSR_TAPS;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_next_bit()};
        end
        return v;
    endfunction

    // **********************************************************************
    // reference model
    // **********************************************************************
    function automatic logic [XLEN-1:0] ref_result(alu_op_e op, logic [XLEN-1:0] a,
                                                   logic [XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << sh;
            OP_SRL:  return a >> sh;
            OP_SLT: begin
                // with signs that differ the negative one is smaller
                if (a[XLEN-1] != b[XLEN-1]) begin
                    return XLEN'(a[XLEN-1]);
                end
                return XLEN'(a < b);
            end
            default: return '0;
        endcase
    endfunction

    // executes in program order, so lane 2 sees lane 1's write
    function automatic es_to_ws_t run_inst(inst_t in);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        es_to_ws_t       o;
        a = model_regs[in.src1];
        b = in.use_imm ? {{(XLEN-IMM_W){in.imm[IMM_W-1]}}, in.imm} : model_regs[in.src2];
        o.gr_we        = in.gr_we;
        o.dest         = in.dest;
        o.final_result = ref_result(in.op, a, b);
        o.pc           = in.pc;
        if (in.gr_we && in.dest != '0) begin
            model_regs[in.dest] = o.final_result;
        end
        return o;
    endfunction

    // sources and dests from r0-r7 keep dependencies frequent
    function automatic inst_t random_inst(logic [XLEN-1:0] pc);
        inst_t in;
        in.op      = alu_op_e'(3'(rand_bits(3)));
        in.use_imm = 1'(rand_bits(1));
        in.imm     = 16'(rand_bits(16));
        in.src1    = 5'(rand_bits(3));
        in.src2    = 5'(rand_bits(3));
        in.dest    = 5'(rand_bits(3));
        in.gr_we   = (rand_bits(3) != 0);
        in.pc      = pc;
        return in;
    endfunction

    function automatic inst_t fixed_inst(alu_op_e op, logic use_imm, logic [15:0] imm,
                                         logic [4:0] src1, logic [4:0] src2,
                                         logic [4:0] dest, logic [XLEN-1:0] pc);
        inst_t in;
        in.op      = op;
        in.use_imm = use_imm;
        in.imm     = imm;
        in.src1    = src1;
        in.src2    = src2;
        in.dest    = dest;
        in.gr_we   = 1'b1;
        in.pc      = pc;
        return in;
    endfunction

    // **********************************************************************
    // checks
    // **********************************************************************
    task automatic abort_run(string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s actual 0x%08h expected 0x%08h", name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic compare_lane(string lane, es_to_ws_t got, es_to_ws_t exp);
        check_value({lane, ".gr_we"}, 32'(got.gr_we), 32'(exp.gr_we));
        check_value({lane, ".dest"}, 32'(got.dest), 32'(exp.dest));
        check_value({lane, ".final_result"}, got.final_result, exp.final_result);
        check_value({lane, ".pc"}, got.pc, exp.pc);
    endtask

    // sample at the falling edge and return on the next rising edge
    task automatic step();
        retire_pair_t exp;
        @(negedge clk);
        s_retire_valid = retire_valid;
        s_issue_ready  = issue_ready;
        if (!issue_ready) begin
            check_value("bundles in flight while issue_ready low", accepted - retired, 3);
        end
        if (retire_valid && retire_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("retire handshake with no bundle outstanding");
            end else begin
                exp = exp_q.pop_front();
                compare_lane("retire_lane1", retire_lane1, exp.lane1);
                compare_lane("retire_lane2", retire_lane2, exp.lane2);
                retired++;
            end
        end
        issue_fire = issue_valid && issue_ready;
        if (issue_fire) begin
            exp.lane1 = run_inst(issue_bundle.slot1);
            exp.lane2 = run_inst(issue_bundle.slot2);
            exp_q.push_back(exp);
            accepted++;
        end
        @(posedge clk);
    endtask

    initial begin
        #(TIMEOUT_NS);
        abort_run("watchdog expired before all bundles retired");
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        issue_valid  = 1'b0;
        issue_bundle = '0;
        retire_ready = 1'b0;
        lfsr         = LFSR_SEED;
        accepted     = 0;
        retired      = 0;
        issue_fire   = 1'b0;
        pending      = 1'b0;
        next_pc      = 32'h0000_1000;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        reset        <= 1'b0;
        retire_ready <= 1'b1;
        step();
        check_value("retire_valid", 32'(s_retire_valid), 0);
        check_value("issue_ready", 32'(s_issue_ready), 1);

        // single bundle into an empty pipe
        // chained signed compare with both lanes writing r1
        issue_valid        <= 1'b1;
        issue_bundle.slot1 <= fixed_inst(OP_ADD, 1'b1, 16'h8001, 5'd0, 5'd0, 5'd1, next_pc);
        issue_bundle.slot2 <= fixed_inst(OP_SLT, 1'b0, 16'h0000, 5'd1, 5'd0, 5'd1,
                                         next_pc + 4);
        next_pc += 8;
        step();
        check_value("issue_valid && issue_ready", 32'(issue_fire), 1);
        issue_valid <= 1'b0;
        step();
        check_value("retire_valid", 32'(s_retire_valid), 0);
        step();
        check_value("retire_valid", 32'(s_retire_valid), 0);
        step();
        check_value("retire_valid", 32'(s_retire_valid), 1);

        // **********************************************************************
        // random bundles under back-pressure
        // **********************************************************************
        while (accepted < NUM_BUNDLES) begin
            if (issue_fire) begin
                pending = 1'b0;
            end
            if (!pending) begin
                if (rand_bits(4) < 11) begin
                    issue_valid        <= 1'b1;
                    issue_bundle.slot1 <= random_inst(next_pc);
                    issue_bundle.slot2 <= random_inst(next_pc + 4);
                    next_pc += 8;
                    pending = 1'b1;
                end else begin
                    issue_valid <= 1'b0;
                end
            end
            retire_ready <= (rand_bits(4) < 10);
            step();
        end

        // drain
        issue_valid <= 1'b0;
        while (retired != accepted) begin
            retire_ready <= (rand_bits(4) < 10);
            step();
        end
        retire_ready <= 1'b1;
        repeat (4) step();
        check_value("retire_valid", 32'(s_retire_valid), 0);

        if (exp_q.size() != 0) begin
            abort_run("bundles left in the model queue after the drain");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule
